// File: include/director_consts.svh
`ifndef DIRECTOR_CONSTS_SVH
`define DIRECTOR_CONSTS_SVH

// Address and metadata widths
`define DIR_VADDR_WIDTH 39
`define DIR_BMETA_WIDTH 16
`define DIR_PRIV_WIDTH 2

// Command queue entries
`define DIR_CMDQ_DEPTH 4

// FE command opcodes
`define DIR_OPCODE_WIDTH 3
`define DIR_OP_STATE_RESET 3'd0
`define DIR_OP_PC_REDIRECTION 3'd1
`define DIR_OP_WAIT 3'd2
`define DIR_OP_ICACHE_FENCE 3'd3
`define DIR_OP_ATTABOY 3'd4

`endif

// File: hw/director_pkg.sv
`include "director_consts.svh"

package director_pkg;

  typedef enum logic [`DIR_OPCODE_WIDTH-1:0]
  {
    e_op_state_reset    = `DIR_OP_STATE_RESET
    , e_op_pc_redirection = `DIR_OP_PC_REDIRECTION
    , e_op_wait           = `DIR_OP_WAIT
    , e_op_icache_fence   = `DIR_OP_ICACHE_FENCE
    , e_op_attaboy        = `DIR_OP_ATTABOY
  } fe_opcode_e;

  typedef enum logic [1:0]
  {
    e_subop_eret               = 2'd0
    , e_subop_trap             = 2'd1
    , e_subop_branch_mispredict = 2'd2
  } redirect_subop_e;

  typedef enum logic [1:0]
  {
    e_not_a_branch           = 2'd0
    , e_incorrect_pred_taken  = 2'd1
    , e_incorrect_pred_ntaken = 2'd2
  } mispredict_reason_e;

  typedef enum logic [1:0]
  {
    e_freeze  = 2'd0
    , e_wait  = 2'd1
    , e_run   = 2'd2
    , e_fence = 2'd3
  } dir_state_e;

  typedef struct packed
  {
    logic                        v;
    logic [`DIR_VADDR_WIDTH-1:0] pc;
    logic [`DIR_BMETA_WIDTH-1:0] branch_metadata_fwd;
  } issue_status_s;

  typedef struct packed
  {
    logic                        v;
    logic [`DIR_VADDR_WIDTH-1:0] npc;
    logic                        branch;
    logic                        btaken;
  } branch_pkt_s;

  typedef struct packed
  {
    logic                        npc_w_v;
    logic [`DIR_VADDR_WIDTH-1:0] npc;
    logic                        unfreeze;
    logic                        wfi;
    logic                        fencei;
    logic                        eret;
    logic                        exception;
    logic                        interrupt;
    logic [`DIR_PRIV_WIDTH-1:0]  priv_n;
  } commit_pkt_s;

  typedef struct packed
  {
    redirect_subop_e             subopcode;
    logic [`DIR_PRIV_WIDTH-1:0]  priv;
    mispredict_reason_e          misprediction_reason;
    logic [`DIR_BMETA_WIDTH-1:0] branch_metadata_fwd;
  } redirect_operands_s;

  // Padded out to the redirect operand width
  typedef struct packed
  {
    logic                        taken;
    logic [`DIR_BMETA_WIDTH-1:0] branch_metadata_fwd;
    logic [`DIR_PRIV_WIDTH+2:0]  padding;
  } attaboy_operands_s;

  typedef union packed
  {
    redirect_operands_s redirect;
    attaboy_operands_s  attaboy;
  } fe_cmd_operands_u;

  typedef struct packed
  {
    fe_opcode_e                  opcode;
    logic [`DIR_VADDR_WIDTH-1:0] vaddr;
    fe_cmd_operands_u            operands;
  } fe_cmd_s;

endpackage

// File: hw/npc_tracker.sv
`include "director_consts.svh"

module npc_tracker
  (input                                 clk_i
   , input                               reset_i

   , input director_pkg::issue_status_s  issue_status_i
   , input director_pkg::branch_pkt_s    br_pkt_i
   , input director_pkg::commit_pkt_s    commit_pkt_i

   , output logic [`DIR_VADDR_WIDTH-1:0] expected_npc_o
   , output logic [`DIR_VADDR_WIDTH-1:0] npc_r_o
   , output logic                        npc_mismatch_o
   , output logic                        poison_isd_o
   , output logic                        last_branch_o
   , output logic                        last_btaken_o
   );

  logic                        npc_w_v;
  logic [`DIR_VADDR_WIDTH-1:0] npc_n;
  logic [`DIR_VADDR_WIDTH-1:0] npc_r;
  logic                        branch_pending_r;
  logic                        btaken_pending_r;

  // Commit write beats a resolving branch
  assign npc_w_v = commit_pkt_i.npc_w_v | br_pkt_i.v;
  assign npc_n   = commit_pkt_i.npc_w_v ? commit_pkt_i.npc : br_pkt_i.npc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      npc_r            <= '0;
      branch_pending_r <= 1'b0;
      btaken_pending_r <= 1'b0;
    end
    else
    begin
      if (npc_w_v)
        npc_r <= npc_n;
      // A valid issue consumes the pending branch info
      if (issue_status_i.v)
      begin
        branch_pending_r <= 1'b0;
        btaken_pending_r <= 1'b0;
      end
      else
      begin
        branch_pending_r <= branch_pending_r | br_pkt_i.branch;
        btaken_pending_r <= btaken_pending_r | br_pkt_i.btaken;
      end
    end
  end

  assign npc_r_o        = npc_r;
  assign expected_npc_o = npc_w_v ? npc_n : npc_r;
  assign npc_mismatch_o = issue_status_i.v & (issue_status_i.pc != expected_npc_o);
  assign poison_isd_o   = commit_pkt_i.npc_w_v | npc_mismatch_o;
  assign last_branch_o  = branch_pending_r | br_pkt_i.branch;
  assign last_btaken_o  = btaken_pending_r | br_pkt_i.btaken;

  a_mismatch_needs_issue: assert property (@(posedge clk_i) disable iff (reset_i)
    npc_mismatch_o |-> issue_status_i.v)
    else $error("NPC mismatch flagged without a valid issue");

endmodule

// File: hw/director_fsm.sv
module director_fsm
  (input          clk_i
   , input        reset_i

   , input        freeze_i
   , input        wfi_i
   , input        redirect_sent_i
   , input        queue_empty_n_i

   , output logic waiting_o
   , output logic suppress_iss_o
   , output logic unfreeze_o
   );

  director_pkg::dir_state_e state_r;
  director_pkg::dir_state_e state_n;

  always_comb
  begin
    state_n = state_r;
    if (freeze_i)
      state_n = director_pkg::e_freeze;
    else
    begin
      unique case (state_r)
        director_pkg::e_freeze:
          state_n = director_pkg::e_wait;
        director_pkg::e_wait:
          state_n = redirect_sent_i ? director_pkg::e_fence : director_pkg::e_wait;
        director_pkg::e_run:
          if (wfi_i)
            state_n = director_pkg::e_wait;
          else if (redirect_sent_i)
            state_n = director_pkg::e_fence;
        // Hold until the FE has drained every queued command
        director_pkg::e_fence:
          state_n = queue_empty_n_i ? director_pkg::e_run : director_pkg::e_fence;
        default:
          state_n = director_pkg::e_freeze;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= director_pkg::e_freeze;
    else
      state_r <= state_n;
  end

  assign waiting_o      = (state_r == director_pkg::e_wait);
  assign suppress_iss_o = (state_r != director_pkg::e_run);
  assign unfreeze_o     = (state_r == director_pkg::e_freeze) & ~freeze_i;

  a_state_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    !$isunknown(state_r) && (state_r inside {director_pkg::e_freeze, director_pkg::e_wait,
                                             director_pkg::e_run, director_pkg::e_fence}))
    else $error("Director FSM in an illegal state");

endmodule

// File: hw/fe_cmd_encoder.sv
`include "director_consts.svh"

module fe_cmd_encoder
  (input director_pkg::commit_pkt_s     commit_pkt_i
   , input director_pkg::issue_status_s issue_status_i
   , input                              irq_waiting_i
   , input                              waiting_i
   , input [`DIR_VADDR_WIDTH-1:0]       expected_npc_i
   , input [`DIR_VADDR_WIDTH-1:0]       npc_r_i
   , input                              npc_mismatch_i
   , input                              last_branch_i
   , input                              last_btaken_i
   , input                              ready_i

   , output director_pkg::fe_cmd_s      cmd_o
   , output logic                       cmd_v_o
   , output logic                       redirect_sent_o
   );

  director_pkg::fe_cmd_s            cmd_n;
  director_pkg::redirect_operands_s redir;
  director_pkg::attaboy_operands_s  attaboy;
  logic                             cmd_event;
  logic                             trap_v;

  // An irq only wakes the core while it sits in wait
  assign trap_v = commit_pkt_i.exception | commit_pkt_i.interrupt | (waiting_i & irq_waiting_i);

  always_comb
  begin
    cmd_n     = '0;
    redir     = '0;
    attaboy   = '0;
    cmd_event = 1'b1;

    if (commit_pkt_i.unfreeze)
    begin
      cmd_n.opcode             = director_pkg::e_op_state_reset;
      cmd_n.vaddr              = npc_r_i;
      redir.priv               = commit_pkt_i.priv_n;
      cmd_n.operands.redirect  = redir;
    end
    else if (commit_pkt_i.wfi)
    begin
      cmd_n.opcode = director_pkg::e_op_wait;
      cmd_n.vaddr  = commit_pkt_i.npc;
    end
    else if (commit_pkt_i.fencei)
    begin
      cmd_n.opcode = director_pkg::e_op_icache_fence;
      cmd_n.vaddr  = commit_pkt_i.npc;
    end
    else if (commit_pkt_i.eret)
    begin
      cmd_n.opcode            = director_pkg::e_op_pc_redirection;
      cmd_n.vaddr             = commit_pkt_i.npc;
      redir.subopcode         = director_pkg::e_subop_eret;
      redir.priv              = commit_pkt_i.priv_n;
      cmd_n.operands.redirect = redir;
    end
    else if (trap_v)
    begin
      cmd_n.opcode            = director_pkg::e_op_pc_redirection;
      cmd_n.vaddr             = commit_pkt_i.npc;
      redir.subopcode         = director_pkg::e_subop_trap;
      redir.priv              = commit_pkt_i.priv_n;
      cmd_n.operands.redirect = redir;
    end
    else if (npc_mismatch_i)
    begin
      cmd_n.opcode              = director_pkg::e_op_pc_redirection;
      cmd_n.vaddr               = expected_npc_i;
      redir.subopcode           = director_pkg::e_subop_branch_mispredict;
      redir.branch_metadata_fwd = issue_status_i.branch_metadata_fwd;
      if (!last_branch_i)
        redir.misprediction_reason = director_pkg::e_not_a_branch;
      else if (last_btaken_i)
        redir.misprediction_reason = director_pkg::e_incorrect_pred_taken;
      else
        redir.misprediction_reason = director_pkg::e_incorrect_pred_ntaken;
      cmd_n.operands.redirect   = redir;
    end
    // Correct prediction on the branch before this issue
    else if (issue_status_i.v & last_branch_i)
    begin
      cmd_n.opcode                = director_pkg::e_op_attaboy;
      cmd_n.vaddr                 = expected_npc_i;
      attaboy.taken               = last_btaken_i;
      attaboy.branch_metadata_fwd = issue_status_i.branch_metadata_fwd;
      cmd_n.operands.attaboy      = attaboy;
    end
    else
      cmd_event = 1'b0;
  end

  assign cmd_o           = cmd_n;
  assign cmd_v_o         = cmd_event & ready_i;
  assign redirect_sent_o = cmd_v_o & (cmd_n.opcode != director_pkg::e_op_attaboy);

endmodule

// File: hw/fe_cmd_queue.sv
`include "director_consts.svh"

module fe_cmd_queue
  (input                          clk_i
   , input                        reset_i

   , input director_pkg::fe_cmd_s cmd_i
   , input                        cmd_v_i
   , output logic                 ready_o

   , output director_pkg::fe_cmd_s cmd_o
   , output logic                 cmd_v_o
   , input                        yumi_i

   , output logic                 empty_n_o
   , output logic                 full_n_o
   );

  localparam int ptr_width_lp = $clog2(`DIR_CMDQ_DEPTH);
  localparam int cnt_width_lp = $clog2(`DIR_CMDQ_DEPTH + 1);

  director_pkg::fe_cmd_s   mem [`DIR_CMDQ_DEPTH];
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic [cnt_width_lp-1:0] count_n;

  assign count_n = count_r + cnt_width_lp'(cmd_v_i) - cnt_width_lp'(yumi_i);

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
      mem[wptr_r] <= cmd_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (cmd_v_i)
        wptr_r <= (wptr_r == ptr_width_lp'(`DIR_CMDQ_DEPTH - 1)) ? '0 : wptr_r + 1'b1;
      if (yumi_i)
        rptr_r <= (rptr_r == ptr_width_lp'(`DIR_CMDQ_DEPTH - 1)) ? '0 : rptr_r + 1'b1;
      count_r <= count_n;
    end
  end

  assign ready_o = (count_r != cnt_width_lp'(`DIR_CMDQ_DEPTH));
  assign cmd_o   = mem[rptr_r];
  assign cmd_v_o = (count_r != '0);

  // Flags for the occupancy after this edge
  assign empty_n_o = (count_n == '0);
  assign full_n_o  = (count_n == cnt_width_lp'(`DIR_CMDQ_DEPTH));

  // Encoder must drop commands rather than push into a full queue
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> ready_o)
    else $error("Command pushed into a full queue");

  a_no_yumi_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> cmd_v_o)
    else $error("FE yumi while the command queue is empty");

endmodule

// File: hw/be_director.sv
`include "director_consts.svh"

module be_director
  (input                                 clk_i
   , input                               reset_i

   , input                               freeze_i
   , input                               irq_waiting_i

   , input director_pkg::issue_status_s  issue_status_i
   , input director_pkg::branch_pkt_s    br_pkt_i
   , input director_pkg::commit_pkt_s    commit_pkt_i

   , output logic [`DIR_VADDR_WIDTH-1:0] expected_npc_o
   , output logic                        poison_isd_o
   , output logic                        suppress_iss_o
   , output logic                        unfreeze_o

   // FE command interface
   , output director_pkg::fe_cmd_s       fe_cmd_o
   , output logic                        fe_cmd_v_o
   , input                               fe_cmd_yumi_i

   , output logic                        cmd_empty_n_o
   , output logic                        cmd_full_n_o
   );

  logic [`DIR_VADDR_WIDTH-1:0] npc_r;
  logic                        npc_mismatch;
  logic                        last_branch;
  logic                        last_btaken;
  logic                        waiting;
  logic                        redirect_sent;
  logic                        queue_ready;
  logic                        cmd_v;
  director_pkg::fe_cmd_s       cmd;

  npc_tracker i_npc_tracker
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.issue_status_i(issue_status_i)
     ,.br_pkt_i(br_pkt_i)
     ,.commit_pkt_i(commit_pkt_i)
     ,.expected_npc_o(expected_npc_o)
     ,.npc_r_o(npc_r)
     ,.npc_mismatch_o(npc_mismatch)
     ,.poison_isd_o(poison_isd_o)
     ,.last_branch_o(last_branch)
     ,.last_btaken_o(last_btaken)
     );

  director_fsm i_director_fsm
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.freeze_i(freeze_i)
     ,.wfi_i(commit_pkt_i.wfi)
     ,.redirect_sent_i(redirect_sent)
     ,.queue_empty_n_i(cmd_empty_n_o)
     ,.waiting_o(waiting)
     ,.suppress_iss_o(suppress_iss_o)
     ,.unfreeze_o(unfreeze_o)
     );

  fe_cmd_encoder i_fe_cmd_encoder
    (.commit_pkt_i(commit_pkt_i)
     ,.issue_status_i(issue_status_i)
     ,.irq_waiting_i(irq_waiting_i)
     ,.waiting_i(waiting)
     ,.expected_npc_i(expected_npc_o)
     ,.npc_r_i(npc_r)
     ,.npc_mismatch_i(npc_mismatch)
     ,.last_branch_i(last_branch)
     ,.last_btaken_i(last_btaken)
     ,.ready_i(queue_ready)
     ,.cmd_o(cmd)
     ,.cmd_v_o(cmd_v)
     ,.redirect_sent_o(redirect_sent)
     );

  fe_cmd_queue i_fe_cmd_queue
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(cmd)
     ,.cmd_v_i(cmd_v)
     ,.ready_o(queue_ready)
     ,.cmd_o(fe_cmd_o)
     ,.cmd_v_o(fe_cmd_v_o)
     ,.yumi_i(fe_cmd_yumi_i)
     ,.empty_n_o(cmd_empty_n_o)
     ,.full_n_o(cmd_full_n_o)
     );

endmodule

// File: include/director_tb_consts.svh
`ifndef DIRECTOR_TB_CONSTS_SVH
`define DIRECTOR_TB_CONSTS_SVH

// Length of the random run in clock cycles
`define TB_NUM_CYCLES 3000
`define TB_CLK_PERIOD 100
`define TB_RESET_CYCLES 4
`define TB_SEED 62

`endif

// File: testbench/tb_director.sv
`include "director_consts.svh"
`include "director_tb_consts.svh"

module tb_director;
  timeunit 1ns;
  timeprecision 1ps;

  logic                        clk_i;
  logic                        reset_i;
  logic                        freeze_i;
  logic                        irq_waiting_i;
  logic                        fe_cmd_yumi_i;
  director_pkg::issue_status_s issue_status_i;
  director_pkg::branch_pkt_s   br_pkt_i;
  director_pkg::commit_pkt_s   commit_pkt_i;
  logic [`DIR_VADDR_WIDTH-1:0] expected_npc_o;
  logic                        poison_isd_o;
  logic                        suppress_iss_o;
  logic                        unfreeze_o;
  director_pkg::fe_cmd_s       fe_cmd_o;
  logic                        fe_cmd_v_o;
  logic                        cmd_empty_n_o;
  logic                        cmd_full_n_o;

  // Reference model state
  logic [31:0]                 rng_state;
  logic [`DIR_VADDR_WIDTH-1:0] m_npc_r;
  logic                        m_branch_pend;
  logic                        m_btaken_pend;
  director_pkg::dir_state_e    m_state;
  director_pkg::dir_state_e    m_state_n;
  director_pkg::fe_cmd_s       m_queue [`DIR_CMDQ_DEPTH];
  int                          m_head;
  int                          m_count;
  int                          m_count_n;

  // Reference model outputs for the current cycle
  logic                        m_npc_w_v;
  logic [`DIR_VADDR_WIDTH-1:0] m_expected;
  logic                        m_mismatch;
  logic                        m_poison;
  logic                        m_last_branch;
  logic                        m_last_btaken;
  director_pkg::fe_cmd_s       m_cmd;
  logic                        m_event;
  logic                        m_cmd_v;
  logic                        m_redirect_sent;

  be_director i_dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.freeze_i(freeze_i)
     ,.irq_waiting_i(irq_waiting_i)
     ,.issue_status_i(issue_status_i)
     ,.br_pkt_i(br_pkt_i)
     ,.commit_pkt_i(commit_pkt_i)
     ,.expected_npc_o(expected_npc_o)
     ,.poison_isd_o(poison_isd_o)
     ,.suppress_iss_o(suppress_iss_o)
     ,.unfreeze_o(unfreeze_o)
     ,.fe_cmd_o(fe_cmd_o)
     ,.fe_cmd_v_o(fe_cmd_v_o)
     ,.fe_cmd_yumi_i(fe_cmd_yumi_i)
     ,.cmd_empty_n_o(cmd_empty_n_o)
     ,.cmd_full_n_o(cmd_full_n_o)
     );

  initial clk_i = 1'b0;
  always #(`TB_CLK_PERIOD / 2) clk_i = ~clk_i;

  function logic [15:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  function logic one_in(input int n);
    return (int'(next_random()) % n) == 0;
  endfunction

  function logic [`DIR_VADDR_WIDTH-1:0] random_addr();
    logic [47:0] r;
    r = {next_random(), next_random(), next_random()};
    return r[`DIR_VADDR_WIDTH-1:0];
  endfunction

  // Commit write first, then a resolved branch, else the held NPC
  function logic [`DIR_VADDR_WIDTH-1:0] forwarded_npc();
    if (commit_pkt_i.npc_w_v)
      return commit_pkt_i.npc;
    else if (br_pkt_i.v)
      return br_pkt_i.npc;
    return m_npc_r;
  endfunction

  task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED: %s expected 0x%h got 0x%h", name, exp, got);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task drive_inputs();
    director_pkg::commit_pkt_s   c;
    director_pkg::branch_pkt_s   b;
    director_pkg::issue_status_s s;
    c = '0;
    b = '0;
    s = '0;
    c.npc_w_v   = one_in(16);
    c.npc       = random_addr();
    c.unfreeze  = one_in(16);
    c.wfi       = one_in(16);
    c.fencei    = one_in(16);
    c.eret      = one_in(16);
    c.exception = one_in(16);
    c.interrupt = one_in(16);
    c.priv_n    = `DIR_PRIV_WIDTH'(next_random());
    b.v      = one_in(4);
    b.npc    = random_addr();
    b.branch = one_in(4);
    b.btaken = b.branch & one_in(2);
    commit_pkt_i = c;
    br_pkt_i     = b;
    // Mostly issue on the expected path so attaboys show up
    s.v                   = one_in(2);
    s.pc                  = one_in(4) ? random_addr() : forwarded_npc();
    s.branch_metadata_fwd = `DIR_BMETA_WIDTH'(next_random());
    issue_status_i = s;
    irq_waiting_i  = one_in(8);
    freeze_i       = freeze_i ? !one_in(4) : one_in(256);
    fe_cmd_yumi_i  = (m_count != 0) && one_in(2);
  endtask

  task model_comb();
    director_pkg::redirect_operands_s redir;
    director_pkg::attaboy_operands_s  boy;
    logic                             trap;
    m_npc_w_v     = commit_pkt_i.npc_w_v | br_pkt_i.v;
    m_expected    = forwarded_npc();
    m_mismatch    = issue_status_i.v && (issue_status_i.pc != m_expected);
    m_poison      = commit_pkt_i.npc_w_v | m_mismatch;
    m_last_branch = m_branch_pend | br_pkt_i.branch;
    m_last_btaken = m_btaken_pend | br_pkt_i.btaken;
    trap = commit_pkt_i.exception | commit_pkt_i.interrupt
           | ((m_state == director_pkg::e_wait) & irq_waiting_i);
    m_cmd   = '0;
    redir   = '0;
    boy     = '0;
    m_event = 1'b1;
    redir.priv = commit_pkt_i.priv_n;
    m_cmd.vaddr = commit_pkt_i.npc;
    if (commit_pkt_i.unfreeze)
    begin
      m_cmd.opcode = director_pkg::e_op_state_reset;
      m_cmd.vaddr  = m_npc_r;
      m_cmd.operands.redirect = redir;
    end
    else if (commit_pkt_i.wfi)
      m_cmd.opcode = director_pkg::e_op_wait;
    else if (commit_pkt_i.fencei)
      m_cmd.opcode = director_pkg::e_op_icache_fence;
    else if (commit_pkt_i.eret || trap)
    begin
      m_cmd.opcode    = director_pkg::e_op_pc_redirection;
      redir.subopcode = commit_pkt_i.eret ? director_pkg::e_subop_eret
                                          : director_pkg::e_subop_trap;
      m_cmd.operands.redirect = redir;
    end
    else if (m_mismatch)
    begin
      redir = '0;
      m_cmd.opcode = director_pkg::e_op_pc_redirection;
      m_cmd.vaddr  = m_expected;
      redir.subopcode           = director_pkg::e_subop_branch_mispredict;
      redir.branch_metadata_fwd = issue_status_i.branch_metadata_fwd;
      if (m_last_branch)
        redir.misprediction_reason = m_last_btaken ? director_pkg::e_incorrect_pred_taken
                                                   : director_pkg::e_incorrect_pred_ntaken;
      else
        redir.misprediction_reason = director_pkg::e_not_a_branch;
      m_cmd.operands.redirect = redir;
    end
    else if (issue_status_i.v && m_last_branch)
    begin
      m_cmd.opcode = director_pkg::e_op_attaboy;
      m_cmd.vaddr  = m_expected;
      boy.taken               = m_last_btaken;
      boy.branch_metadata_fwd = issue_status_i.branch_metadata_fwd;
      m_cmd.operands.attaboy  = boy;
    end
    else
    begin
      m_cmd   = '0;
      m_event = 1'b0;
    end
    m_cmd_v         = m_event && (m_count != `DIR_CMDQ_DEPTH);
    m_redirect_sent = m_cmd_v && (m_cmd.opcode != director_pkg::e_op_attaboy);
    m_count_n       = m_count + int'(m_cmd_v) - int'(fe_cmd_yumi_i);
    m_state_n       = m_state;
    if (freeze_i)
      m_state_n = director_pkg::e_freeze;
    else if (m_state == director_pkg::e_freeze)
      m_state_n = director_pkg::e_wait;
    else if (m_state == director_pkg::e_wait && m_redirect_sent)
      m_state_n = director_pkg::e_fence;
    else if (m_state == director_pkg::e_run)
    begin
      if (commit_pkt_i.wfi)
        m_state_n = director_pkg::e_wait;
      else if (m_redirect_sent)
        m_state_n = director_pkg::e_fence;
    end
    else if (m_state == director_pkg::e_fence && m_count_n == 0)
      m_state_n = director_pkg::e_run;
  endtask

  task check_outputs();
    check_value("expected_npc_o", 64'(expected_npc_o), 64'(m_expected));
    check_value("poison_isd_o", 64'(poison_isd_o), 64'(m_poison));
    check_value("suppress_iss_o", 64'(suppress_iss_o), 64'(m_state != director_pkg::e_run));
    check_value("unfreeze_o", 64'(unfreeze_o),
                64'((m_state == director_pkg::e_freeze) && !freeze_i));
    check_value("i_dut.cmd_v", 64'(i_dut.cmd_v), 64'(m_cmd_v));
    check_value("fe_cmd_v_o", 64'(fe_cmd_v_o), 64'(m_count != 0));
    check_value("cmd_empty_n_o", 64'(cmd_empty_n_o), 64'(m_count_n == 0));
    check_value("cmd_full_n_o", 64'(cmd_full_n_o), 64'(m_count_n == `DIR_CMDQ_DEPTH));
    if (m_count != 0)
      check_value("fe_cmd_o", 64'(fe_cmd_o), 64'(m_queue[m_head]));
  endtask

  task model_update();
    if (m_npc_w_v)
      m_npc_r = m_expected;
    if (issue_status_i.v)
    begin
      m_branch_pend = 1'b0;
      m_btaken_pend = 1'b0;
    end
    else
    begin
      m_branch_pend = m_branch_pend | br_pkt_i.branch;
      m_btaken_pend = m_btaken_pend | br_pkt_i.btaken;
    end
    if (m_cmd_v)
      m_queue[(m_head + m_count) % `DIR_CMDQ_DEPTH] = m_cmd;
    if (fe_cmd_yumi_i)
      m_head = (m_head + 1) % `DIR_CMDQ_DEPTH;
    m_count = m_count_n;
    m_state = m_state_n;
  endtask

  initial
  begin
    #((`TB_NUM_CYCLES + 20) * `TB_CLK_PERIOD);
    $display("Timeout: the random run did not finish in time");
    $display("Test failed");
    $fatal(1);
  end

  initial
  begin
    rng_state      = `TB_SEED;
    reset_i        = 1'b1;
    freeze_i       = 1'b0;
    irq_waiting_i  = 1'b0;
    fe_cmd_yumi_i  = 1'b0;
    issue_status_i = '0;
    br_pkt_i       = '0;
    commit_pkt_i   = '0;
    m_npc_r        = '0;
    m_branch_pend  = 1'b0;
    m_btaken_pend  = 1'b0;
    m_state        = director_pkg::e_freeze;
    m_head         = 0;
    m_count        = 0;
    repeat (`TB_RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int cyc = 0; cyc < `TB_NUM_CYCLES; cyc++)
    begin
      drive_inputs();
      // Settle time before the next rising edge
      #(`TB_CLK_PERIOD * 2 / 5);
      model_comb();
      check_outputs();
      @(posedge clk_i);
      model_update();
      @(negedge clk_i);
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
hw/director_pkg.sv
hw/npc_tracker.sv
hw/director_fsm.sv
hw/fe_cmd_encoder.sv
hw/fe_cmd_queue.sv
hw/be_director.sv
testbench/tb_director.sv

// File: Makefile
# Verilator flow for the back-end director

VERILATOR ?= verilator
TOP       ?= tb_director
RTL_TOP   ?= be_director
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
